// ==== Makefile ====
# Verilator build and run of the expansion glue testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module cpc_expansion_tb -f src.f -o cpc_expansion_sim
	./obj_dir/cpc_expansion_sim

clean:
	rm -rf obj_dir

// ==== cpc_exp_pkg.sv ====
// Shared definitions for the expansion glue
//   RAM address union with flat and ROM page views
//   ROM page numbers for base and bad-extension ROMs
//   Cartridge entry points and paging port
//   I/O port bytes and shadow RAM store addresses

package cpc_exp_pkg;

	////////////////////////////////////////
	// External RAM address

	typedef union packed {
		logic [22:0] flat;
		struct packed {
			logic        rom;     // Upper half of RAM holds ROM pages
			logic  [7:0] page;
			logic [13:0] offset;  // 16 KB inside a page
		} fields;
	} ram_addr_u;

	////////////////////////////////////////
	// ROM pages

	localparam logic [8:0] ROM_PAGE_OS     = 9'h000;
	localparam logic [8:0] ROM_PAGE_BASIC  = 9'h100;
	localparam logic [8:0] ROM_PAGE_AMSDOS = 9'h107;
	localparam logic [8:0] ROM_PAGE_MF2    = 9'h1FF;
	localparam logic [8:0] ROM_PAGE_BAD    = 9'h1EE;  // Unused page for a malformed extension

	localparam logic [4:0] ROM_IDX_TAPE = 5'd4;  // First index that is not a ROM

	////////////////////////////////////////
	// Cartridge

	localparam logic [15:0] MF2_NMI_ADDR  = 16'h0066;
	localparam logic [15:0] MF2_HIDE_ADDR = 16'h0065;
	localparam logic [13:0] MF2_PORT_BASE = 14'h3FBA;  // FEE8 and FEEA

	// Upper port bytes
	localparam logic [7:0] PORT_GA        = 8'h7F;
	localparam logic [7:0] PORT_CRTC_SEL  = 8'hBC;
	localparam logic [7:0] PORT_CRTC_DATA = 8'hBD;
	localparam logic [7:0] PORT_PPI       = 8'hF7;
	localparam logic [7:0] PORT_ROMSEL    = 8'hDF;

	// Where each write-only register lands in cartridge RAM
	localparam logic [12:0] SHADOW_PEN_IDX   = 13'h1FCF;
	localparam logic [12:0] SHADOW_BORDER    = 13'h1FDF;
	localparam logic [12:0] SHADOW_PEN_BASE  = 13'h1F90;  // Plus pen 0..15
	localparam logic [12:0] SHADOW_MODE      = 13'h1FEF;
	localparam logic [12:0] SHADOW_BANK      = 13'h1FFF;
	localparam logic [12:0] SHADOW_CRTC_SEL  = 13'h1CFF;
	localparam logic [12:0] SHADOW_CRTC_BASE = 13'h1DB0;  // Plus CRTC register 0..15
	localparam logic [12:0] SHADOW_PPI       = 13'h17FF;
	localparam logic [12:0] SHADOW_ROMSEL    = 13'h1AAC;

endpackage

// ==== cpc_expansion_sva.sv ====
// Concurrent checks on the expansion glue
//   RAM write only after a host pulse
//   Host pulse only while not waiting
//   NMI cleared when the cartridge pages in

`timescale 1ns/1ps

module cpc_exp_sva import cpc_exp_pkg::*; (
	input logic        clk_sys,
	input logic        reset,
	input logic        ioctl_wr,
	input logic        ioctl_wait,
	input logic        boot_wr,
	input logic        m1,
	input logic [15:0] cpu_addr,
	input logic        nmi,
	input logic        mf2_active
);

	write_after_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(boot_wr) |-> $past(ioctl_wr))
		else $error("RAM write without a host pulse");

	no_pulse_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wait |-> !ioctl_wr)
		else $error("Download pulse while ioctl_wait is high");

	// Fetch of the NMI vector pages the cartridge in
	nmi_entry: assert property (@(posedge clk_sys) disable iff (reset)
		(nmi && m1 && !$past(m1) && cpu_addr == MF2_NMI_ADDR) |=> (!nmi && mf2_active))
		else $error("NMI still pending after entry at 0066");

endmodule

// Loader and control signals meet at the top level
bind cpc_expansion_top cpc_exp_sva sva_i (
	.clk_sys, .reset, .ioctl_wr, .ioctl_wait, .boot_wr,
	.m1, .cpu_addr, .nmi, .mf2_active
);

// ==== cpc_expansion_tb.sv ====
// Testbench for the expansion glue
//   Directed tests for ROM download, NMI entry, register shadow and paging
//   Compare tasks for RAM addresses, bytes and bits
//   Watchdog

`timescale 1ns/1ps

module cpc_expansion_tb import cpc_exp_pkg::*; ();

	localparam int TESTS           = 5;
	localparam int CYCLES_PER_TEST = 200;
	localparam int CLK_PERIOD_NS   = 100;

	logic        clk_sys;
	logic        reset;
	logic        ioctl_download;
	logic  [7:0] ioctl_index;
	logic [15:0] ioctl_file_ext;
	logic [24:0] ioctl_addr;
	logic  [7:0] ioctl_dout;
	logic        ioctl_wr;
	logic        ioctl_wait;
	logic [15:0] cpu_addr;
	logic  [7:0] cpu_dout;
	ram_addr_u   ram_a;
	logic        mem_rd;
	logic        mem_wr;
	logic        io_wr;
	logic        m1;
	logic        key_nmi;
	logic        model;
	logic  [1:0] mf2_mode;
	logic        nmi;
	logic  [7:0] mf2_din;
	logic        mf2_active;
	logic        mem_oe;
	logic        mem_we;
	ram_addr_u   mem_addr;
	logic        mem_bank;
	logic  [7:0] mem_din;
	integer      seed;

	tb_clock clock_i (.clk_sys, .reset);

	cpc_expansion_top dut_i (.*);

	////////////////////////////////////////
	// Compare tasks

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic addr_match(input string name, input ram_addr_u exp, input ram_addr_u act);
		if (act !== exp)
			abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp.flat, act.flat));
	endtask

	task automatic byte_match(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic bit_match(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
	endtask

	////////////////////////////////////////
	// Bus helpers

	// Host byte pulse that returns inside the first RAM write cycle
	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic wait_idle(input string name);
		int n;
		n = 0;
		while (ioctl_wait) begin
			@(negedge clk_sys);
			n++;
			if (n > 10)
				abort_run($sformatf("%s: ioctl_wait never went low", name));
		end
	endtask

	task automatic cpu_write(input string name, input logic [15:0] addr,
			input logic [7:0] data, input logic exp_we);
		@(posedge clk_sys);
		cpu_addr   <= addr;
		ram_a.flat <= {7'd0, addr};
		cpu_dout   <= data;
		mem_rd     <= 1'b0;
		mem_wr     <= 1'b1;
		@(negedge clk_sys);
		bit_match(name, exp_we, mem_we);
		@(posedge clk_sys);
		mem_wr <= 1'b0;
	endtask

	task automatic read_shadow(input string name, input logic [15:0] addr, input logic [7:0] exp);
		@(posedge clk_sys);
		cpu_addr   <= addr;
		ram_a.flat <= {7'd0, addr};
		mem_rd     <= 1'b1;
		@(posedge clk_sys);   // RAM read latency
		@(negedge clk_sys);
		byte_match(name, exp, mf2_din);
	endtask

	// Returns once the store has landed
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		cpu_addr <= addr;
		cpu_dout <= data;
		mem_rd   <= 1'b0;
		io_wr    <= 1'b1;
		@(posedge clk_sys);
		io_wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		@(posedge clk_sys);
		cpu_addr <= addr;
		m1       <= 1'b1;
		@(posedge clk_sys);
		m1 <= 1'b0;
		@(negedge clk_sys);
	endtask

	// Base ROM pages in slot order OS, BASIC, AMSDOS, cartridge
	function automatic logic [8:0] slot_page(input logic [1:0] slot);
		case (slot)
			2'd0: return 9'h000;
			2'd1: return 9'h100;
			2'd2: return 9'h107;
			default: return 9'h1FF;
		endcase
	endfunction

	////////////////////////////////////////
	// Directed tests

	task automatic base_rom_test();
		logic [31:0] rnd;
		logic  [2:0] slot;
		ram_addr_u   exp;
		@(posedge clk_sys);
		ioctl_index    <= 8'd0;
		ioctl_download <= 1'b1;
		for (int s = 0; s < 8; s++) begin
			slot     = s[2:0];
			rnd      = $random(seed);
			exp.flat = {slot_page(slot[1:0]), rnd[13:0]};
			send_byte({8'd0, slot, rnd[13:0]}, rnd[21:14]);
			bit_match("base_rom wait", 1'b1, ioctl_wait);
			bit_match("base_rom write", 1'b1, mem_we);
			addr_match("base_rom address", exp, mem_addr);
			bit_match("base_rom bank", slot[2], mem_bank);   // Slots 4..7 in bank 1
			byte_match("base_rom data", rnd[21:14], mem_din);
			wait_idle("base_rom");
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
	endtask

	task automatic expansion_rom_test();
		ram_addr_u exp;
		exp.flat = {1'b1, 8'hA7, 14'h0123};
		@(posedge clk_sys);
		ioctl_index    <= 8'd1;
		ioctl_file_ext <= "A7";
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_sys);  // Extension taken on the download edge
		send_byte(25'h0000123, 8'h5A);
		bit_match("expansion_rom write bank 0", 1'b1, mem_we);
		addr_match("expansion_rom address bank 0", exp, mem_addr);
		bit_match("expansion_rom first bank", 1'b0, mem_bank);
		@(negedge clk_sys);
		bit_match("expansion_rom write bank 1", 1'b1, mem_we);
		addr_match("expansion_rom address bank 1", exp, mem_addr);
		bit_match("expansion_rom second bank", 1'b1, mem_bank);
		wait_idle("expansion_rom");
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(posedge clk_sys);
		ram_a    <= exp;
		cpu_addr <= 16'hC123;
		mem_rd   <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		bit_match("expansion_rom loaded page read", 1'b1, mem_oe);
		@(posedge clk_sys);
		ram_a.flat <= {1'b1, 8'h55, 14'h0123};  // Never loaded
		@(posedge clk_sys);
		@(negedge clk_sys);
		bit_match("expansion_rom empty page read", 1'b0, mem_oe);
		@(posedge clk_sys);
		mem_rd <= 1'b0;
	endtask

	task automatic nmi_entry_test();
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		@(posedge clk_sys);
		key_nmi <= 1'b0;
		@(negedge clk_sys);
		bit_match("nmi_entry button", 1'b1, nmi);
		m1_fetch(16'h0066);
		bit_match("nmi_entry nmi cleared", 1'b0, nmi);
		bit_match("nmi_entry paged in", 1'b1, mf2_active);
		cpu_write("nmi_entry cartridge write", 16'h2100, 8'hC3, 1'b0);
		read_shadow("nmi_entry read back", 16'h2100, 8'hC3);
	endtask

	task automatic shadow_test();
		io_write(16'h7F00, 8'h05);  // Select pen 5
		io_write(16'h7F00, 8'h4C);  // Its colour
		io_write(16'hBC00, 8'h0C);  // Select CRTC register 12
		io_write(16'hBD00, 8'h2A);
		read_shadow("shadow pen 5", 16'h3F95, 8'h4C);
		read_shadow("shadow crtc select", 16'h3CFF, 8'h0C);
		read_shadow("shadow crtc register 12", 16'h3DBC, 8'h2A);
	endtask

	task automatic paging_test();
		io_write(16'hFEEA, 8'h00);
		@(negedge clk_sys);
		bit_match("paging out", 1'b0, mf2_active);
		cpu_write("paging write reaches RAM", 16'h2100, 8'h11, 1'b1);
		io_write(16'hFEE8, 8'h00);
		@(negedge clk_sys);
		bit_match("paging back in", 1'b1, mf2_active);
		m1_fetch(16'h0065);         // Hide the cartridge
		io_write(16'hFEEA, 8'h00);
		io_write(16'hFEE8, 8'h00);
		@(negedge clk_sys);
		bit_match("paging while hidden", 1'b0, mf2_active);
	endtask

	////////////////////////////////////////
	// Run

	initial begin
		seed = 32'h620a_d053;
		ioctl_download <= 1'b0;
		ioctl_index    <= 8'd0;
		ioctl_file_ext <= 16'd0;
		ioctl_addr     <= 25'd0;
		ioctl_dout     <= 8'd0;
		ioctl_wr       <= 1'b0;
		cpu_addr       <= 16'd0;
		cpu_dout       <= 8'd0;
		ram_a          <= '0;
		mem_rd         <= 1'b0;
		mem_wr         <= 1'b0;
		io_wr          <= 1'b0;
		m1             <= 1'b0;
		key_nmi        <= 1'b0;
		model          <= 1'b0;
		mf2_mode       <= 2'd0;  // Cartridge enabled
		@(negedge reset);
		base_rom_test();
		expansion_rom_test();
		nmi_entry_test();
		shadow_test();
		paging_test();
		$display("TEST PASSED");
		$finish;
	end

	initial begin
		#((TESTS * CYCLES_PER_TEST + 10) * CLK_PERIOD_NS);
		abort_run("Watchdog timeout, the tests did not finish in time");
	end

endmodule

// ==== cpc_expansion_top.sv ====
// Expansion glue top level
//   ROM loader, page map, cartridge control,
//   cartridge RAM and RAM port mux

`timescale 1ns/1ps

module cpc_expansion_top import cpc_exp_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	// Download port
	input  logic        ioctl_download,
	input  logic  [7:0] ioctl_index,
	input  logic [15:0] ioctl_file_ext,
	input  logic [24:0] ioctl_addr,
	input  logic  [7:0] ioctl_dout,
	input  logic        ioctl_wr,
	output logic        ioctl_wait,
	// CPU side
	input  logic [15:0] cpu_addr,
	input  logic  [7:0] cpu_dout,
	input  ram_addr_u   ram_a,
	input  logic        mem_rd,
	input  logic        mem_wr,
	input  logic        io_wr,
	input  logic        m1,
	input  logic        key_nmi,
	input  logic        model,
	input  logic  [1:0] mf2_mode,
	output logic        nmi,
	output logic  [7:0] mf2_din,
	output logic        mf2_active,  // LED
	// External RAM
	output logic        mem_oe,
	output logic        mem_we,
	output ram_addr_u   mem_addr,
	output logic        mem_bank,
	output logic  [7:0] mem_din
);

	logic       boot_wr;
	ram_addr_u  boot_a;
	logic       boot_bank;
	logic [7:0] boot_dout;
	logic       rom_loading;
	logic       page_set;
	logic [7:0] page_set_idx;
	logic       rom_mask;
	logic       mf2_rom_en;
	logic       mf2_ram_en;
	logic       mf2_port_hit;

	rom_loader loader_i (
		.clk_sys, .reset,
		.ioctl_download, .ioctl_index, .ioctl_file_ext, .ioctl_addr,
		.ioctl_dout, .ioctl_wr, .ioctl_wait,
		.boot_wr, .boot_a, .boot_bank, .boot_dout, .rom_loading,
		.page_set, .page_set_idx
	);

	rom_page_map page_map_i (
		.clk_sys, .reset, .page_set, .page_set_idx, .ram_a,
		.mf2_disable(mf2_mode[1]),
		.rom_mask
	);

	mf2_control control_i (
		.clk_sys, .reset, .cpu_addr, .io_wr, .m1, .key_nmi, .mf2_mode,
		.nmi, .mf2_rom_en, .mf2_ram_en, .mf2_port_hit, .mf2_active
	);

	mf2_shadow_ram shadow_i (
		.clk_sys, .cpu_addr, .cpu_dout, .ram_a, .io_wr, .mem_wr, .mem_rd,
		.mf2_ram_en, .mf2_port_hit, .mf2_din
	);

	ram_port_mux mux_i (
		.clk_sys, .reset, .rom_loading,
		.boot_wr, .boot_a, .boot_bank, .boot_dout,
		.ram_a, .cpu_addr, .cpu_dout, .mem_rd, .mem_wr, .model,
		.mf2_rom_en, .mf2_ram_en, .rom_mask,
		.mem_oe, .mem_we, .mem_addr, .mem_bank, .mem_din
	);

endmodule

// ==== mf2_control.sv ====
// Cartridge control
//   NMI button arming and entry at 0066
//   Hide on fetch at 0065
//   Paging through ports FEE8 and FEEA
//   Window enables for cartridge ROM and RAM

`timescale 1ns/1ps

module mf2_control import cpc_exp_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] cpu_addr,
	input  logic        io_wr,
	input  logic        m1,
	input  logic        key_nmi,
	input  logic  [1:0] mf2_mode,     // 0 enabled, 1 hidden, 2 disabled
	output logic        nmi,
	output logic        mf2_rom_en,
	output logic        mf2_ram_en,
	output logic        mf2_port_hit,
	output logic        mf2_active
);

	logic old_key_nmi;
	logic old_m1;
	logic old_io_wr;
	logic mf2_en;      // Paged into the low 16 KB
	logic mf2_hidden;
	logic key_edge;
	logic m1_edge;
	logic io_edge;

	assign key_edge     = key_nmi & ~old_key_nmi;
	assign m1_edge      = m1 & ~old_m1;
	assign io_edge      = io_wr & ~old_io_wr;
	assign mf2_port_hit = io_edge & (cpu_addr[15:2] == MF2_PORT_BASE);

	assign mf2_rom_en = mf2_en & (cpu_addr[15:13] == 3'b000);  // 0000-1FFF
	assign mf2_ram_en = mf2_en & (cpu_addr[15:13] == 3'b001);  // 2000-3FFF
	assign mf2_active = mf2_en;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_key_nmi <= 1'b0;
			old_m1      <= 1'b0;
			old_io_wr   <= 1'b0;
			mf2_en      <= 1'b0;
			mf2_hidden  <= |mf2_mode;
			nmi         <= 1'b0;
		end else begin
			old_key_nmi <= key_nmi;
			old_m1      <= m1;
			old_io_wr   <= io_wr;

			if (key_edge && !mf2_en && !mf2_mode[1])
				nmi <= 1'b1;

			// Page in when the CPU takes the NMI vector
			if (nmi && m1_edge && cpu_addr == MF2_NMI_ADDR) begin
				mf2_en     <= 1'b1;
				mf2_hidden <= 1'b0;
				nmi        <= 1'b0;
			end
			if (mf2_en && m1_edge && cpu_addr == MF2_HIDE_ADDR)
				mf2_hidden <= 1'b1;

			// A hidden cartridge never pages back in
			if (mf2_port_hit)
				mf2_en <= ~cpu_addr[1] & ~mf2_hidden;
		end
	end

endmodule

// ==== mf2_shadow_ram.sv ====
// Cartridge RAM
//   8 KB RAM in the 2000-3FFF window
//   Store-address decoder for write-only hardware registers
//   Pen index and CRTC register tracking
//   Read data, FF when not selected

`timescale 1ns/1ps

module mf2_shadow_ram import cpc_exp_pkg::*; (
	input  logic        clk_sys,
	input  logic [15:0] cpu_addr,
	input  logic  [7:0] cpu_dout,
	input  ram_addr_u   ram_a,
	input  logic        io_wr,
	input  logic        mem_wr,
	input  logic        mem_rd,
	input  logic        mf2_ram_en,
	input  logic        mf2_port_hit,
	output logic  [7:0] mf2_din
);

	logic  [7:0] shadow [8192];
	logic        old_io_wr;
	logic  [4:0] pen_idx;
	logic  [3:0] crtc_reg;
	logic [12:0] store_addr;
	logic        store_hit;
	logic        st_we;        // Registered I/O store
	logic [12:0] st_addr;
	logic  [7:0] st_data;
	logic        wr_en;
	logic [12:0] wr_addr;
	logic  [7:0] wr_data;
	logic  [7:0] ram_out;

	////////////////////////////////////////
	// Register store decode

	always_comb begin
		case (cpu_addr[15:8])
			PORT_GA: begin
				case (cpu_dout[7:6])
					2'b00: store_addr = SHADOW_PEN_IDX;
					2'b01: store_addr = pen_idx[4] ? SHADOW_BORDER :
						(SHADOW_PEN_BASE | {9'd0, pen_idx[3:0]});
					2'b10: store_addr = SHADOW_MODE;
					default: store_addr = SHADOW_BANK;
				endcase
			end
			PORT_CRTC_SEL:  store_addr = SHADOW_CRTC_SEL;
			PORT_CRTC_DATA: store_addr = SHADOW_CRTC_BASE | {9'd0, crtc_reg};
			PORT_PPI:       store_addr = SHADOW_PPI;
			PORT_ROMSEL:    store_addr = SHADOW_ROMSEL;
			default:        store_addr = 13'd0;  // Not shadowed
		endcase
	end

	assign store_hit = io_wr & ~old_io_wr & ~mf2_port_hit & (|store_addr);

	// I/O store wins over a CPU write
	assign wr_en   = st_we | (mem_wr & mf2_ram_en);
	assign wr_addr = st_we ? st_addr : ram_a.flat[12:0];
	assign wr_data = st_we ? st_data : cpu_dout;

	assign mf2_din = (mf2_ram_en & mem_rd) ? ram_out : 8'hFF;

	always_ff @(posedge clk_sys) begin
		old_io_wr <= io_wr;
		st_we     <= store_hit;
		if (store_hit) begin
			st_addr <= store_addr;
			st_data <= cpu_dout;
			if (cpu_addr[15:8] == PORT_GA && cpu_dout[7:6] == 2'b00)
				pen_idx <= cpu_dout[4:0];
			if (cpu_addr[15:8] == PORT_CRTC_SEL)
				crtc_reg <= cpu_dout[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			shadow[wr_addr] <= wr_data;
		ram_out <= shadow[ram_a.flat[12:0]];
	end

endmodule

// ==== ram_port_mux.sv ====
// External RAM port mux
//   Loader path during reset or ROM download
//   CPU path gated by cartridge windows and ROM mask
//   Model bank latch

`timescale 1ns/1ps

module ram_port_mux import cpc_exp_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        rom_loading,
	input  logic        boot_wr,
	input  ram_addr_u   boot_a,
	input  logic        boot_bank,
	input  logic  [7:0] boot_dout,
	input  ram_addr_u   ram_a,
	input  logic [15:0] cpu_addr,
	input  logic  [7:0] cpu_dout,
	input  logic        mem_rd,
	input  logic        mem_wr,
	input  logic        model,
	input  logic        mf2_rom_en,
	input  logic        mf2_ram_en,
	input  logic        rom_mask,
	output logic        mem_oe,
	output logic        mem_we,
	output ram_addr_u   mem_addr,
	output logic        mem_bank,
	output logic  [7:0] mem_din
);

	logic model_q;
	logic boot_sel;

	assign boot_sel = reset | rom_loading;

	always_ff @(posedge clk_sys) begin
		if (reset)
			model_q <= model;  // Applied on reset only
	end

	always_comb begin
		if (boot_sel) begin
			mem_oe   = 1'b0;
			mem_we   = boot_wr;
			mem_addr = boot_a;
			mem_bank = boot_bank;
			mem_din  = boot_dout;
		end else begin
			mem_oe        = mem_rd & ~mf2_ram_en & ~rom_mask;
			mem_we        = mem_wr & ~mf2_ram_en & ~mf2_rom_en;
			mem_addr.flat = mf2_rom_en ? {ROM_PAGE_MF2, cpu_addr[13:0]} : ram_a.flat;
			mem_bank      = model_q;
			mem_din       = cpu_dout;
		end
	end

endmodule

// ==== rom_loader.sv ====
// ROM download mapper
//   Extension decode to an expansion page
//   Base ROM slot table
//   Byte write sequencer with single or dual bank writes

`timescale 1ns/1ps

module rom_loader import cpc_exp_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_download,
	input  logic  [7:0] ioctl_index,
	input  logic [15:0] ioctl_file_ext,
	input  logic [24:0] ioctl_addr,
	input  logic  [7:0] ioctl_dout,
	input  logic        ioctl_wr,
	output logic        ioctl_wait,
	output logic        boot_wr,
	output ram_addr_u   boot_a,
	output logic        boot_bank,
	output logic  [7:0] boot_dout,
	output logic        rom_loading,
	output logic        page_set,
	output logic  [7:0] page_set_idx
);

	logic        busy;          // Byte in flight
	logic        dual;          // Bank 1 write still to do
	logic        old_download;
	logic  [8:0] exp_page;      // Page latched at download start
	logic  [8:0] ext_page;
	logic  [4:0] dig_hi;
	logic  [4:0] dig_lo;
	logic  [8:0] base_page;
	logic        is_exp;
	logic        first_bank;
	logic        slot_ok;
	ram_addr_u   target;

	// Valid flag and value of one hex character
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] d;
		d = 5'd0;
		if (c >= "0" && c <= "9")
			d = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			d = {1'b1, c[3:0] + 4'd9};
		return d;
	endfunction

	assign rom_loading = ioctl_download && (ioctl_index[4:0] < ROM_IDX_TAPE);
	assign is_exp      = (ioctl_index != 8'd0);
	assign slot_ok     = is_exp || (ioctl_addr[24:14] < 11'd8);
	assign ioctl_wait  = busy;
	assign boot_wr     = busy;   // Every busy cycle is one RAM write

	always_comb begin
		dig_hi   = hex_digit(ioctl_file_ext[15:8]);
		dig_lo   = hex_digit(ioctl_file_ext[7:0]);
		ext_page = ROM_PAGE_BAD;
		if (dig_hi[4])
			ext_page[7:4] = dig_hi[3:0];
		if (dig_lo[4])
			ext_page[3:0] = dig_lo[3:0];
		if (ioctl_file_ext == "ZZ")
			ext_page = 9'h000;
	end

	////////////////////////////////////////
	// Target of the current byte

	always_comb begin
		case (ioctl_addr[15:14])
			2'd0: base_page = ROM_PAGE_OS;
			2'd1: base_page = ROM_PAGE_BASIC;
			2'd2: base_page = ROM_PAGE_AMSDOS;
			default: base_page = ROM_PAGE_MF2;
		endcase
		target.fields.offset = ioctl_addr[13:0];
		if (is_exp) begin
			target.fields.rom  = exp_page[8];
			target.fields.page = exp_page[7:0] + ioctl_addr[21:14];
			first_bank         = &ioctl_index[7:6];
		end else begin
			{target.fields.rom, target.fields.page} = base_page;
			first_bank = ioctl_addr[16];    // Slots 4..7 go to bank 1
		end
	end

	////////////////////////////////////////
	// Write sequencer

	always_ff @(posedge clk_sys) begin
		old_download <= ioctl_download;
		if (reset) begin
			busy     <= 1'b0;
			dual     <= 1'b0;
			page_set <= 1'b0;
		end else begin
			page_set <= 1'b0;
			if (ioctl_download && !old_download && is_exp)
				exp_page <= ext_page;

			if (busy) begin
				if (dual) begin
					dual      <= 1'b0;
					boot_bank <= 1'b1;  // Repeat into the second bank
				end else begin
					busy         <= 1'b0;
					page_set     <= boot_a.fields.rom;
					page_set_idx <= boot_a.fields.page;
				end
			end else if (rom_loading && ioctl_wr && slot_ok) begin
				busy      <= 1'b1;
				dual      <= (ioctl_index[7:6] == 2'b01 || |ioctl_index[5:0]) && !first_bank;
				boot_a    <= target;
				boot_bank <= first_bank;
				boot_dout <= ioctl_dout;
			end
		end
	end

endmodule

// ==== rom_page_map.sv ====
// Loaded ROM page map
//   One bit per ROM page, set by the loader
//   Registered read mask for CPU ROM reads

`timescale 1ns/1ps

module rom_page_map import cpc_exp_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       page_set,
	input  logic [7:0] page_set_idx,
	input  ram_addr_u  ram_a,
	input  logic       mf2_disable,
	output logic       rom_mask
);

	logic [255:0] loaded = '0;  // One bit per ROM page
	logic         ff_page;

	assign ff_page = &ram_a.fields.page;  // Cartridge ROM page

	always_ff @(posedge clk_sys) begin
		if (page_set)
			loaded[page_set_idx] <= 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			rom_mask <= 1'b0;
		else
			rom_mask <= ram_a.fields.rom &
				(~loaded[ram_a.fields.page] | (ff_page & mf2_disable));
	end

endmodule

// ==== src.f ====
cpc_exp_pkg.sv
rom_loader.sv
rom_page_map.sv
mf2_control.sv
mf2_shadow_ram.sv
ram_port_mux.sv
cpc_expansion_top.sv
tb_clock.sv
cpc_expansion_sva.sv
cpc_expansion_tb.sv

// ==== tb_clock.sv ====
// Testbench clock and reset
//   100 ns clock
//   Reset held for the first 3 cycles

`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		reset <= 1'b1;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule
